/* dv/datapath_assert.sv */
/*
 * Concurrent checks on the datapath registers, bound to the top level.
 * All checks except the reset check are off while reset is high.
 */
`timescale 1ns/10ps

module datapath_assert (
    input logic                    clk,
    input logic                    reset,
    input neander_pkg::dp_ctrl_t   ctrl,
    input neander_pkg::dp_status_t status,
    input neander_pkg::dp_debug_t  dbg
);

    int fail_count = 0;                         // Read by the testbench at the end

    // ------------------------------------------------------------------
    // Register stability
    // ------------------------------------------------------------------
    pc_hold_a: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.pc_inc || ctrl.pc_load) |=> $stable(dbg.pc))
        else begin
            fail_count++;
            $error("PC changed without pc_inc or pc_load");
        end

    sp_hold_a: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.sp_inc || ctrl.sp_dec) |=> $stable(dbg.sp))
        else begin
            fail_count++;
            $error("SP changed without sp_inc or sp_dec");
        end

    // Z follows the byte loaded from memory
    z_load_a: assert property (@(posedge clk) disable iff (reset)
        (ctrl.ac_load && ctrl.nz_load && ctrl.ac_src == neander_pkg::AC_MEM)
        |=> (status.z == (dbg.ac == '0)))
        else begin
            fail_count++;
            $error("Z does not match AC after a load from memory");
        end

    pc_reset_a: assert property (@(posedge clk) reset |-> (dbg.pc == '0))
        else begin
            fail_count++;
            $error("PC is not zero while reset is high");   // Async clear
        end

endmodule

/* dv/datapath_input.txt */
# loads pc_inc..c_load | addr_sel idx_sel wdata_sel alu_b_sel ac_src x_src alu_op | mem_data_in
# expected after the edge: mem_addr mem_data_out ac x pc sp nzc
00000100000000 0 0 0 0 0 0 0 34  0000 00 00 00 0000 00FF 000
00000010000000 0 0 0 0 0 0 0 12  0000 00 00 00 0000 00FF 000
01000000000000 0 0 0 0 0 0 0 00  0000 00 00 00 1234 00FF 000
10000000000000 0 0 0 0 0 0 0 00  0000 00 00 00 1235 00FF 000
00001000000000 1 0 0 0 0 0 0 00  1235 00 00 00 1235 00FF 000
11000000000000 0 0 0 0 0 0 0 00  1235 00 00 00 1234 00FF 000
00000000100010 0 0 0 0 1 0 0 7F  1235 7F 7F 00 1234 00FF 000
00000000100011 0 0 0 0 0 0 0 01  1235 80 80 00 1234 00FF 100
00000000100011 0 0 0 0 0 0 0 90  1235 10 10 00 1234 00FF 001
00000000100011 0 0 0 1 0 0 1 00  1235 0F 0F 00 1234 00FF 001
00000000100011 0 0 0 0 0 0 1 0F  1235 00 00 00 1234 00FF 011
00000000100011 0 0 0 1 0 0 1 00  1235 FF FF 00 1234 00FF 100
00000000100011 0 0 0 0 0 0 2 0F  1235 0F 0F 00 1234 00FF 000
00000000100011 0 0 0 0 0 0 4 FF  1235 F0 F0 00 1234 00FF 100
00000000100011 0 0 0 0 0 0 5 00  1235 0F 0F 00 1234 00FF 000
00000000100010 0 0 0 0 1 0 0 80  1235 80 80 00 1234 00FF 100
00000000100011 0 0 0 0 0 0 6 00  1235 00 00 00 1234 00FF 011
00000000100010 0 0 0 0 1 0 0 03  1235 03 03 00 1234 00FF 001
00000000100011 0 0 0 0 0 0 7 00  1235 01 01 00 1234 00FF 001
00000000000001 0 0 0 0 0 0 1 05  1235 01 01 00 1234 00FF 000
00000000010000 0 0 0 0 0 0 0 FF  1235 01 01 FF 1234 00FF 000
00000000001000 0 0 0 0 0 0 0 00  1235 01 01 00 1234 00FF 000
00000000000100 0 0 0 0 0 0 0 00  1235 01 01 FF 1234 00FF 000
00000000011000 0 0 0 0 0 0 0 42  1235 01 01 42 1234 00FF 000
00000000100010 0 0 0 0 2 0 0 00  1235 42 42 42 1234 00FF 000
00000000100011 0 0 0 2 0 0 0 00  1235 84 84 42 1234 00FF 100
00000000010000 0 0 0 0 0 1 0 00  1235 84 84 84 1234 00FF 100
00000000000100 0 0 3 0 0 0 0 00  1235 83 84 83 1234 00FF 100
00000110000000 0 0 0 0 0 0 0 FF  1235 84 84 83 1234 00FF 100
00001000000000 0 0 0 0 0 0 0 00  FFFF 84 84 83 1234 00FF 100
00000000010000 0 1 0 0 0 0 0 02  0001 84 84 02 1234 00FF 100
00010000000000 0 2 0 0 0 0 0 00  00FD 84 84 02 1234 00FE 100
00100000000000 0 2 0 0 0 0 0 00  00FE 84 84 02 1234 00FF 100
00110000000000 0 0 0 0 0 0 0 00  FFFF 84 84 02 1234 00FE 100
00001000000000 2 0 1 0 0 0 0 00  00FE 34 84 02 1234 00FE 100
00000000000000 0 1 2 0 0 0 0 00  0100 12 84 02 1234 00FE 100

/* dv/datapath_tb.sv */
/*
 * Runs the datapath from dv/datapath_input.txt, one control word per line.
 * A word is driven 2 ns after a rising edge and its expected values are
 * checked 1 ns after the next edge, while that word is still applied.
 * Expected RI nibbles are tracked here from the rdm_load_lo and ri_load bits.
 * Lines starting with # are comments. The run stops at the first mismatch.
 */
`timescale 1ns/10ps

module datapath_tb;

    localparam int CLK_PERIOD    = 100;         // ns
    localparam int RESET_TIMEOUT = 20;          // Cycles
    localparam int RUN_LIMIT     = 300;         // Cycles for the whole run

    logic                    clk;
    logic                    reset;
    neander_pkg::dp_ctrl_t   ctrl;
    neander_pkg::data_t      mem_data_in;
    neander_pkg::addr_t      mem_addr;
    neander_pkg::data_t      mem_data_out;
    neander_pkg::dp_status_t status;
    neander_pkg::dp_debug_t  dbg;
    int                      line_no;           // File line, for messages

    neander_datapath #(
        .SP_RESET (16'h00FF)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .mem_data_in  (mem_data_in),
        .mem_addr     (mem_addr),
        .mem_data_out (mem_data_out),
        .status       (status),
        .dbg          (dbg)
    );

    bind neander_datapath datapath_assert assert_i (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (ctrl),
        .status (status),
        .dbg    (dbg)
    );

    // ------------------------------------------------------------------
    // Reporting and checks
    // ------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_field(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("CHECK FAILED at %0d ns: line %0d %s is %h, expected %h",
                                $time, line_no, name, got, exp));
        end
    endtask

    // PC clear, SP at its reset value, AC, X, RI and flags clear
    task automatic check_reset_state();
        check_field("pc", dbg.pc, 16'h0000);
        check_field("sp", dbg.sp, 16'h00FF);
        check_field("ac", dbg.ac, 16'h0000);
        check_field("x", dbg.x, 16'h0000);
        check_field("flags", {status.n, status.z, status.c}, 16'h0000);
        check_field("opcode", status.opcode, 16'h0000);
        check_field("sub_opcode", status.sub_opcode, 16'h0000);
        check_field("mem_addr", mem_addr, 16'h0000);        // REM clear, no index
        check_field("mem_data_out", mem_data_out, 16'h0000); // WD_AC, AC is 0
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #2 reset = 1'b0;                        // Same offset as the stimulus
    end

    // Limit on the whole run
    initial begin
        #(CLK_PERIOD * RUN_LIMIT);
        abort_run("Timeout: the run did not finish within the cycle limit");
    end

    // ------------------------------------------------------------------
    // Stimulus and checks
    // ------------------------------------------------------------------
    initial begin
        int          fd;
        int          waited;
        int          fields;
        int          vec_count;
        string       text;
        logic [13:0] loads;                     // pc_inc first, c_load last
        logic [3:0]  a_sel, i_sel, w_sel, b_sel;
        logic [3:0]  a_src, x_src, op;
        logic [7:0]  din;
        logic [15:0] exp_addr, exp_pc, exp_sp;
        logic [7:0]  exp_dout, exp_ac, exp_x;
        logic [2:0]  exp_nzc;
        logic [7:0]  exp_rdm_lo;                // RDM low byte as the lines load it
        logic [7:0]  exp_ri;                    // Opcode byte as the lines load it

        ctrl        = '0;                       // All enables low
        mem_data_in = '0;
        line_no     = 0;
        vec_count   = 0;
        exp_rdm_lo  = '0;
        exp_ri      = '0;
        fd = $fopen("dv/datapath_input.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the input file dv/datapath_input.txt");
        end

        waited = 0;
        while (reset !== 1'b0) begin
            if (waited == RESET_TIMEOUT) begin
                abort_run("Reset was not released within the timeout");
            end
            @(posedge clk);
            waited++;
        end
        #1;
        check_reset_state();

        while ($fgets(text, fd) != 0) begin
            line_no++;
            if (text[0] == "#" || text[0] == "\n" || text[0] == "\r") begin
                continue;
            end
            fields = $sscanf(text, "%b %h %h %h %h %h %h %h %h %h %h %h %h %h %h %b",
                             loads, a_sel, i_sel, w_sel, b_sel, a_src, x_src, op, din,
                             exp_addr, exp_dout, exp_ac, exp_x, exp_pc, exp_sp, exp_nzc);
            if (fields != 16) begin
                abort_run($sformatf("Input file ends early: line %0d has %0d of 16 fields",
                                    line_no, fields));
            end
            vec_count++;
            #1;                                 // Edge + 2 ns
            ctrl = {loads, a_sel[1:0], i_sel[1:0], w_sel[1:0], b_sel[1:0],
                    a_src[1:0], x_src[0], op[2:0]};     // Field order of dp_ctrl_t
            mem_data_in = din;
            if (loads[6]) begin
                exp_ri = exp_rdm_lo;            // RI takes the RDM byte held before the edge
            end
            if (loads[8]) begin
                exp_rdm_lo = din;
            end
            @(posedge clk);                     // Word takes effect here
            #1;
            check_field("mem_addr", mem_addr, exp_addr);
            check_field("mem_data_out", mem_data_out, exp_dout);
            check_field("ac", dbg.ac, exp_ac);
            check_field("x", dbg.x, exp_x);
            check_field("pc", dbg.pc, exp_pc);
            check_field("sp", dbg.sp, exp_sp);
            check_field("flags", {status.n, status.z, status.c}, exp_nzc);
            check_field("opcode", status.opcode, exp_ri[7:4]);
            check_field("sub_opcode", status.sub_opcode, exp_ri[3:0]);
        end
        $fclose(fd);

        if (vec_count == 0) begin
            abort_run("The input file holds no data lines");
        end

        // Idle cycle so the one-cycle checks on the last word complete
        #1;
        ctrl = '0;
        @(posedge clk);
        #1;

        if (dut_i.assert_i.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run($sformatf("%0d concurrent assertion failures were reported",
                                dut_i.assert_i.fail_count));
        end
    end

endmodule

/* logic/addr_unit.sv */
/*
 * Address side of the datapath: PC, SP, REM and RDM.
 * RDM bytes load from mem_data_in whenever their enable is high, there
 * is no read strobe. mem_addr is combinational and wraps at 16 bits.
 */
`timescale 1ns/10ps

module addr_unit #(
    parameter neander_pkg::addr_t SP_RESET = 16'h00FF   // Stack top after reset
) (
    input  logic                  clk,
    input  logic                  reset,
    input  neander_pkg::dp_ctrl_t ctrl,
    input  neander_pkg::data_t    mem_data_in,
    input  neander_pkg::data_t    x,            // Index from operand unit
    output neander_pkg::addr_t    pc,
    output neander_pkg::addr_t    sp,
    output neander_pkg::addr_t    rdm,
    output neander_pkg::addr_t    mem_addr
);

    localparam int DW = neander_pkg::DATA_W;
    localparam int AW = neander_pkg::ADDR_W;

    neander_pkg::addr_t rem;
    neander_pkg::addr_t rem_in;                 // REM source mux
    neander_pkg::addr_t idx;                    // Offset added to REM

    // ------------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pc_load) begin
            pc <= rdm;                          // Jump target from RDM
        end else if (ctrl.pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Stack pointer, grows downward
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sp <= SP_RESET;
        end else if (ctrl.sp_dec) begin
            sp <= sp - 1'b1;                    // Push side, checked first
        end else if (ctrl.sp_inc) begin
            sp <= sp + 1'b1;                    // Pop side
        end
    end

    // REM source
    always_comb begin
        case (ctrl.addr_sel)
            neander_pkg::SEL_RDM: rem_in = rdm;
            neander_pkg::SEL_PC:  rem_in = pc;
            neander_pkg::SEL_SP:  rem_in = sp;
            default:              rem_in = rdm;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rem <= '0;
        end else if (ctrl.rem_load) begin
            rem <= rem_in;
        end
    end

    // ------------------------------------------------------------------
    // RDM, two-byte operand fetch
    // ------------------------------------------------------------------
    // Each byte has its own enable, both may load in one cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdm <= '0;
        end else begin
            if (ctrl.rdm_load_lo) begin
                rdm[DW-1:0] <= mem_data_in;
            end
            if (ctrl.rdm_load_hi) begin
                rdm[AW-1:DW] <= mem_data_in;
            end
        end
    end

    // ------------------------------------------------------------------
    // Indexed memory address
    // ------------------------------------------------------------------
    always_comb begin
        case (ctrl.idx_sel)
            neander_pkg::IDX_NONE: idx = '0;
            neander_pkg::IDX_X:    idx = {{(AW-DW){1'b0}}, x};  // X is unsigned
            neander_pkg::IDX_SP:   idx = sp;
            default:               idx = '0;
        endcase
    end

    assign mem_addr = rem + idx;                // Carry out of bit 15 dropped

endmodule

/* logic/neander_alu.sv */
/*
 * Combinational ALU, no carry input.
 * Carry out is the add carry, the no-borrow bit of a subtract (A >= B),
 * or the bit shifted out. Logic operations clear it.
 */
`timescale 1ns/10ps

module neander_alu (
    input  neander_pkg::data_t   a,           // Accumulator side
    input  neander_pkg::data_t   b,           // Selected B operand
    input  neander_pkg::alu_op_e op,
    output neander_pkg::data_t   result,
    output logic                 carry
);

    // One extra bit for carry and borrow
    logic [neander_pkg::DATA_W:0] sum_ext;
    logic [neander_pkg::DATA_W:0] diff_ext;

    assign sum_ext  = {1'b0, a} + {1'b0, b};
    assign diff_ext = {1'b0, a} - {1'b0, b};   // Top bit set on borrow

    // ------------------------------------------------------------------
    // Operation select
    // ------------------------------------------------------------------
    always_comb begin
        result = '0;
        carry  = 1'b0;                          // Logic ops leave it clear
        case (op)
            neander_pkg::ALU_ADD: begin
                result = sum_ext[neander_pkg::DATA_W-1:0];
                carry  = sum_ext[neander_pkg::DATA_W];      // Out of bit 7
            end
            neander_pkg::ALU_SUB: begin
                result = diff_ext[neander_pkg::DATA_W-1:0];
                carry  = ~diff_ext[neander_pkg::DATA_W];    // A >= B unsigned
            end
            neander_pkg::ALU_AND: result = a & b;
            neander_pkg::ALU_OR:  result = a | b;
            neander_pkg::ALU_XOR: result = a ^ b;
            neander_pkg::ALU_NOT: result = ~a;
            neander_pkg::ALU_SHL: begin
                result = a << 1;                            // Zero in at bit 0
                carry  = a[neander_pkg::DATA_W-1];
            end
            neander_pkg::ALU_SHR: begin
                result = a >> 1;                            // Logical, zero in
                carry  = a[0];
            end
            default: begin
                result = '0;
                carry  = 1'b0;
            end
        endcase
    end

endmodule

/* logic/neander_datapath.sv */
/*
 * Accumulator datapath top, driven cycle by cycle by an external control unit.
 * There is no handshake. A stall is a cycle with every enable low.
 * All outputs are combinational from the current register state.
 */
`timescale 1ns/10ps

module neander_datapath #(
    parameter neander_pkg::addr_t SP_RESET = 16'h00FF  // Passed to address unit
) (
    input  logic                    clk,
    input  logic                    reset,
    input  neander_pkg::dp_ctrl_t   ctrl,
    input  neander_pkg::data_t      mem_data_in,
    output neander_pkg::addr_t      mem_addr,
    output neander_pkg::data_t      mem_data_out,
    output neander_pkg::dp_status_t status,
    output neander_pkg::dp_debug_t  dbg
);

    // ------------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------------
    neander_pkg::addr_t pc;
    neander_pkg::addr_t sp;
    neander_pkg::addr_t rdm;
    neander_pkg::data_t ac;
    neander_pkg::data_t x;
    neander_pkg::data_t alu_b;
    neander_pkg::data_t alu_result;
    logic               alu_carry;

    // PC, SP, REM, RDM and the address mux
    addr_unit #(
        .SP_RESET   (SP_RESET)
    ) addr_unit_i (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .mem_data_in (mem_data_in),
        .x           (x),
        .pc          (pc),
        .sp          (sp),
        .rdm         (rdm),
        .mem_addr    (mem_addr)
    );

    // AC, X, RI, flags and data muxes
    operand_unit operand_unit_i (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .mem_data_in  (mem_data_in),
        .pc           (pc),
        .rdm          (rdm),
        .alu_result   (alu_result),
        .alu_carry    (alu_carry),
        .ac           (ac),
        .x            (x),
        .alu_b        (alu_b),
        .mem_data_out (mem_data_out),
        .status       (status)
    );

    neander_alu alu_i (
        .a      (ac),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .carry  (alu_carry)
    );

    // Debug register view
    assign dbg.pc = pc;
    assign dbg.sp = sp;
    assign dbg.ac = ac;
    assign dbg.x  = x;

endmodule

/* logic/neander_pkg.sv */
/*
 * Shared widths, select codes and packed buses of the accumulator datapath.
 * The address word must be exactly twice the data word, because the RDM
 * and the PC are split into a low byte and a high byte.
 * Select codes that are not listed fall back to the first value.
 */
package neander_pkg;

    // ------------------------------------------------------------------
    // Widths and word types
    // ------------------------------------------------------------------
    localparam int DATA_W = 8;              // Accumulator and memory byte
    localparam int ADDR_W = 16;             // 64 KB address space

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // ------------------------------------------------------------------
    // Select codes
    // ------------------------------------------------------------------
    // REM source
    typedef enum logic [1:0] {SEL_RDM = 2'd0, SEL_PC = 2'd1, SEL_SP = 2'd2} addr_sel_e;

    // Offset added to REM on the way to mem_addr
    typedef enum logic [1:0] {IDX_NONE = 2'd0, IDX_X = 2'd1, IDX_SP = 2'd2} idx_sel_e;

    typedef enum logic [1:0] {
        WD_AC    = 2'd0,                    // STA, PUSH
        WD_PC_LO = 2'd1,                    // CALL, return address low byte
        WD_PC_HI = 2'd2,                    // CALL, return address high byte
        WD_X     = 2'd3                     // STX
    } wdata_sel_e;

    typedef enum logic [1:0] {B_MEM = 2'd0, B_ONE = 2'd1, B_X = 2'd2} alu_b_sel_e;

    typedef enum logic [1:0] {AC_ALU = 2'd0, AC_MEM = 2'd1, AC_X = 2'd2} ac_src_e;

    typedef enum logic {XS_MEM = 1'b0, XS_AC = 1'b1} x_src_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_NOT = 3'd5,                     // Ignores B
        ALU_SHL = 3'd6,
        ALU_SHR = 3'd7
    } alu_op_e;

    // ------------------------------------------------------------------
    // Buses between control unit and datapath
    // ------------------------------------------------------------------
    // Control word, 28 bits, MSB first in this order
    typedef struct packed {
        logic       pc_inc;
        logic       pc_load;                // Wins over pc_inc
        logic       sp_inc;
        logic       sp_dec;                 // Wins over sp_inc
        logic       rem_load;
        logic       rdm_load_lo;
        logic       rdm_load_hi;
        logic       ri_load;
        logic       ac_load;
        logic       x_load;
        logic       x_inc;
        logic       x_dec;
        logic       nz_load;
        logic       c_load;
        addr_sel_e  addr_sel;
        idx_sel_e   idx_sel;
        wdata_sel_e wdata_sel;
        alu_b_sel_e alu_b_sel;
        ac_src_e    ac_src;
        x_src_e     x_src;
        alu_op_e    alu_op;
    } dp_ctrl_t;

    // Decode inputs back to the control unit
    typedef struct packed {
        logic [3:0] opcode;                 // RI high nibble
        logic [3:0] sub_opcode;             // RI low nibble
        logic       n;
        logic       z;
        logic       c;
    } dp_status_t;

    // Register view for debug and checking
    typedef struct packed {
        addr_t pc;
        addr_t sp;
        data_t ac;
        data_t x;
    } dp_debug_t;

endpackage

/* logic/operand_unit.sv */
/*
 * Operand side of the datapath: AC, X, RI and the N/Z/C flags.
 * The AC and X sources come from the control word, RI is not decoded here.
 * N and Z follow the AC input value even when AC itself does not load.
 */
`timescale 1ns/10ps

module operand_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  neander_pkg::dp_ctrl_t   ctrl,
    input  neander_pkg::data_t      mem_data_in,
    input  neander_pkg::addr_t      pc,           // For return address pushes
    input  neander_pkg::addr_t      rdm,          // Low byte feeds RI
    input  neander_pkg::data_t      alu_result,
    input  logic                    alu_carry,
    output neander_pkg::data_t      ac,
    output neander_pkg::data_t      x,
    output neander_pkg::data_t      alu_b,
    output neander_pkg::data_t      mem_data_out,
    output neander_pkg::dp_status_t status
);

    localparam int DW = neander_pkg::DATA_W;
    localparam int AW = neander_pkg::ADDR_W;

    neander_pkg::data_t ri;
    neander_pkg::data_t ac_in;
    neander_pkg::data_t x_in;
    logic               n_flag;
    logic               z_flag;
    logic               c_flag;

    // ------------------------------------------------------------------
    // Input muxes
    // ------------------------------------------------------------------
    always_comb begin
        case (ctrl.ac_src)
            neander_pkg::AC_ALU: ac_in = alu_result;
            neander_pkg::AC_MEM: ac_in = mem_data_in;   // LDA, LDI, POP
            neander_pkg::AC_X:   ac_in = x;             // TXA
            default:             ac_in = alu_result;
        endcase
    end

    // TAX when XS_AC, otherwise LDX from memory
    assign x_in = (ctrl.x_src == neander_pkg::XS_AC) ? ac : mem_data_in;

    always_comb begin
        case (ctrl.alu_b_sel)
            neander_pkg::B_MEM: alu_b = mem_data_in;
            neander_pkg::B_ONE: alu_b = {{(DW-1){1'b0}}, 1'b1};   // INC and DEC
            neander_pkg::B_X:   alu_b = x;
            default:            alu_b = mem_data_in;
        endcase
    end

    // Write data, all four codes used
    always_comb begin
        case (ctrl.wdata_sel)
            neander_pkg::WD_AC:    mem_data_out = ac;
            neander_pkg::WD_PC_LO: mem_data_out = pc[DW-1:0];
            neander_pkg::WD_PC_HI: mem_data_out = pc[AW-1:DW];
            neander_pkg::WD_X:     mem_data_out = x;
            default:               mem_data_out = ac;
        endcase
    end

    // ------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ac <= '0;
        end else if (ctrl.ac_load) begin
            ac <= ac_in;
        end
    end

    // Load, then increment, then decrement
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x <= '0;
        end else if (ctrl.x_load) begin
            x <= x_in;
        end else if (ctrl.x_inc) begin
            x <= x + 1'b1;                      // 0xFF wraps to 0x00
        end else if (ctrl.x_dec) begin
            x <= x - 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ri <= '0;
        end else if (ctrl.ri_load) begin
            ri <= rdm[DW-1:0];                  // Opcode byte
        end
    end

    // Flags, N/Z and C have separate enables so CMP can set C alone
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            n_flag <= 1'b0;
            z_flag <= 1'b0;
            c_flag <= 1'b0;
        end else begin
            if (ctrl.nz_load) begin
                n_flag <= ac_in[DW-1];
                z_flag <= (ac_in == '0);
            end
            if (ctrl.c_load) begin
                c_flag <= alu_carry;
            end
        end
    end

    // ------------------------------------------------------------------
    // Status back to control unit
    // ------------------------------------------------------------------
    assign status.opcode     = ri[DW-1:DW-4];
    assign status.sub_opcode = ri[3:0];         // Stack ops and index mode
    assign status.n          = n_flag;
    assign status.z          = z_flag;
    assign status.c          = c_flag;

endmodule

/* project.f */
logic/neander_pkg.sv
logic/neander_alu.sv
logic/addr_unit.sv
logic/operand_unit.sv
logic/neander_datapath.sv
dv/datapath_assert.sv
dv/datapath_tb.sv
